// ==== compile.f ====
+incdir+tests
hdl/exec_pkg.sv
hdl/regfile_pkg.sv
hdl/panda_risc_v_alu.sv
hdl/int_exec_unit.sv
hdl/mul_unit.sv
hdl/wb_arbiter.sv
hdl/reg_file.sv
hdl/exec_cluster.sv
tests/tb_exec_cluster.sv

// ==== Bender.yml ====
package:
  name: exec_cluster

sources:
  - files:
      - hdl/exec_pkg.sv
      - hdl/regfile_pkg.sv
      - hdl/panda_risc_v_alu.sv
      - hdl/int_exec_unit.sv
      - hdl/mul_unit.sv
      - hdl/wb_arbiter.sv
      - hdl/reg_file.sv
      - hdl/exec_cluster.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_exec_cluster.sv

// ==== tests/tb_model.svh ====
`ifndef tb_model_svh
`define tb_model_svh

// expected ALU result, shifts only look at the low five bits of b
function automatic logic [xlen-1:0] alu_model(input logic [alu_op_w-1:0] op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
	logic [shamt_w-1:0] sh;
	sh = b[shamt_w-1:0];
	case (op)
		op_add: return a + b;
		op_sub: return a - b;
		op_equ: return {{(xlen-1){1'b0}}, a == b};
		op_nequ: return {{(xlen-1){1'b0}}, a != b};
		op_sgn_lt: return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
		op_sgn_geq: return {{(xlen-1){1'b0}}, $signed(a) >= $signed(b)};
		op_usgn_lt: return {{(xlen-1){1'b0}}, a < b};
		op_usgn_geq: return {{(xlen-1){1'b0}}, a >= b};
		op_xor: return a ^ b;
		op_or: return a | b;
		op_and: return a & b;
		op_sll: return a << sh;
		op_srl: return a >> sh;
		op_sra: return $signed(a) >>> sh;
		default: return '0;
	endcase
endfunction

// full 64-bit products, then pick the word
function automatic logic [xlen-1:0] mul_model(input logic [mul_op_w-1:0] op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
	logic [2*xlen-1:0]        pu;
	logic signed [2*xlen-1:0] ps;
	pu = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
	ps = $signed({{xlen{a[xlen-1]}}, a}) * $signed({{xlen{b[xlen-1]}}, b});
	case (op)
		mul_lo: return pu[xlen-1:0]; // same for any signedness
		mul_hu: return pu[2*xlen-1:xlen];
		default: return ps[2*xlen-1:xlen];
	endcase
endfunction

task automatic abort_run();
	$display("TEST FAILED");
	$fatal(1);
endtask

task automatic check_reg(input logic [reg_addr_w-1:0] idx, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
	if (got !== exp) begin
		$display("Fail rd_data x%0d: got %h, expected %h", idx, got, exp);
		abort_run();
	end
endtask

task automatic check_busy(input logic got, input logic exp);
	if (got !== exp) begin
		$display("Fail mul_busy: got %h, expected %h", got, exp);
		abort_run();
	end
endtask

`endif

// ==== tests/tb_exec_cluster.sv ====
`timescale 1ns/100ps

module tb_exec_cluster import exec_pkg::*, regfile_pkg::*;;

	logic                  clk;
	logic                  arst_n;
	logic                  alu_issue;
	logic [alu_op_w-1:0]   alu_op;
	logic [xlen-1:0]       alu_a;
	logic [xlen-1:0]       alu_b;
	logic [reg_addr_w-1:0] alu_rd;
	logic                  mul_issue;
	logic [mul_op_w-1:0]   mul_op;
	logic [xlen-1:0]       mul_a;
	logic [xlen-1:0]       mul_b;
	logic [reg_addr_w-1:0] mul_rd;
	logic                  mul_busy;
	logic [reg_addr_w-1:0] rd_addr;
	logic [xlen-1:0]       rd_data;

	integer                seed;
	logic [xlen-1:0]       shadow [reg_count]; // expected register contents
	logic [reg_addr_w-1:0] exp_rd [512];
	logic [xlen-1:0]       exp_val [512];

	`include "tb_model.svh"

	exec_cluster i_dut (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [reg_addr_w-1:0] rand_index();
		logic [31:0] r;
		r = rand_word();
		return r[reg_addr_w-1:0];
	endfunction

	function automatic logic [xlen-1:0] rand_operand();
		logic [31:0] r;
		r = rand_word();
		case (r[3:0])
			4'd0: return '0;
			4'd1: return '1;
			4'd2: return {1'b1, {(xlen-1){1'b0}}};
			default: return rand_word();
		endcase
	endfunction

	task automatic expect_reg(input logic [reg_addr_w-1:0] idx, input logic [xlen-1:0] exp);
		@(posedge clk);
		rd_addr <= idx;
		@(negedge clk);
		check_reg(idx, rd_data, exp);
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < reg_count; i++) begin
			expect_reg(reg_addr_w'(i), shadow[i]);
		end
	endtask

	task automatic wait_mul_idle();
		int cycles;
		cycles = 0;
		while (mul_busy && (cycles < 200)) begin
			@(negedge clk);
			cycles++;
		end
		if (mul_busy) begin
			$display("multiplier never finished, mul_busy still high after 200 cycles");
			abort_run();
		end
	endtask

	// back to back integer issues, each result read in the cycle after its write
	task automatic run_int_stream(input int n, input int mul_slot, input int avoid_rd,
			input logic [mul_op_w-1:0] m_op, input logic [xlen-1:0] m_a,
			input logic [xlen-1:0] m_b, input logic [reg_addr_w-1:0] m_rd);
		logic [alu_op_w-1:0]   op;
		logic [xlen-1:0]       a;
		logic [xlen-1:0]       b;
		logic [reg_addr_w-1:0] rd;
		for (int p = 0; p < n + 3; p++) begin
			@(posedge clk);
			if (p < n) begin
				op = (p < 14) ? alu_op_w'(p) : alu_op_w'(rand_word() % 14);
				a = rand_operand();
				b = rand_operand();
				rd = rand_index();
				if (int'(rd) == avoid_rd) begin
					rd = rd + 1'b1; // keep clear of the pending multiply
				end
				if (p % 25 == 24) begin
					rd = '0;
				end
				exp_rd[p] = rd;
				exp_val[p] = (rd == '0) ? '0 : alu_model(op, a, b);
				alu_issue <= 1'b1;
				alu_op <= op;
				alu_a <= a;
				alu_b <= b;
				alu_rd <= rd;
			end else begin
				alu_issue <= 1'b0;
			end
			if (p == mul_slot) begin
				mul_issue <= 1'b1;
				mul_op <= m_op;
				mul_a <= m_a;
				mul_b <= m_b;
				mul_rd <= m_rd;
			end else begin
				mul_issue <= 1'b0;
			end
			if (p >= 3) begin
				rd_addr <= exp_rd[p-3]; // written two edges after the issue edge
			end
			@(negedge clk);
			if (p >= 3) begin
				check_reg(exp_rd[p-3], rd_data, exp_val[p-3]);
				shadow[exp_rd[p-3]] = exp_val[p-3];
			end
		end
	endtask

	task automatic run_mul(input logic [mul_op_w-1:0] op, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b, input logic [reg_addr_w-1:0] rd);
		logic [xlen-1:0] exp;
		exp = mul_model(op, a, b);
		@(negedge clk);
		check_busy(mul_busy, 1'b0);
		@(posedge clk);
		mul_issue <= 1'b1;
		mul_op <= op;
		mul_a <= a;
		mul_b <= b;
		mul_rd <= rd;
		@(posedge clk);
		mul_issue <= 1'b0;
		@(negedge clk);
		check_busy(mul_busy, 1'b1);
		wait_mul_idle();
		expect_reg(rd, exp);
		shadow[rd] = exp;
	endtask

	initial begin
		logic [mul_op_w-1:0]   m_op;
		logic [xlen-1:0]       m_a;
		logic [xlen-1:0]       m_b;
		logic [reg_addr_w-1:0] m_rd;
		int                    k;
		int                    n;
		int                    slot;
		seed = 89641;
		arst_n = 1'b0;
		alu_issue = 1'b0;
		alu_op = '0;
		alu_a = '0;
		alu_b = '0;
		alu_rd = '0;
		mul_issue = 1'b0;
		mul_op = '0;
		mul_a = '0;
		mul_b = '0;
		mul_rd = '0;
		rd_addr = '0;
		for (int i = 0; i < reg_count; i++) begin
			shadow[i] = '0;
		end
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		@(negedge clk);
		check_busy(mul_busy, 1'b0); // idle out of reset
		check_all_regs();

		run_int_stream(400, -1, -1, mul_lo, '0, '0, '0);
		check_all_regs();

		for (int i = 0; i < 60; i++) begin
			m_op = mul_op_w'(i % 3);
			m_a = rand_operand();
			m_b = rand_operand();
			if (i < 12) begin
				k = i / 3; // every sign pair for each op
				m_a[xlen-1] = k[0];
				m_b[xlen-1] = k[1];
			end
			m_rd = rand_index();
			if (m_rd == '0) begin
				m_rd = reg_addr_w'(1);
			end
			run_mul(m_op, m_a, m_b, m_rd);
		end

		// multiplies under integer back-pressure
		for (int r = 0; r < 6; r++) begin
			m_op = mul_op_w'(rand_word() % 3);
			m_a = rand_operand();
			m_b = rand_operand();
			m_rd = rand_index();
			if (m_rd == '0) begin
				m_rd = reg_addr_w'(7);
			end
			slot = int'(rand_word() % 4);
			n = slot + 40 + int'(rand_word() % 20);
			run_int_stream(n, slot, int'(m_rd), m_op, m_a, m_b, m_rd);
			check_busy(mul_busy, 1'b1); // still stalled behind the integer writes
			wait_mul_idle();
			shadow[m_rd] = mul_model(m_op, m_a, m_b);
			check_all_regs();
		end

		$display("TEST OK");
		$finish;
	end

endmodule

// ==== hdl/exec_cluster.sv ====
`timescale 1ns/100ps

module exec_cluster import exec_pkg::*, regfile_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	// integer issue
	input  logic                  alu_issue,
	input  logic [alu_op_w-1:0]   alu_op,
	input  logic [xlen-1:0]       alu_a,
	input  logic [xlen-1:0]       alu_b,
	input  logic [reg_addr_w-1:0] alu_rd,
	// multiply issue
	input  logic                  mul_issue,
	input  logic [mul_op_w-1:0]   mul_op,
	input  logic [xlen-1:0]       mul_a,
	input  logic [xlen-1:0]       mul_b,
	input  logic [reg_addr_w-1:0] mul_rd,
	output logic                  mul_busy,
	// register read port
	input  logic [reg_addr_w-1:0] rd_addr,
	output logic [xlen-1:0]       rd_data
);

	logic                  int_wb_valid;
	logic [reg_addr_w-1:0] int_wb_rd;
	logic [xlen-1:0]       int_wb_data;

	logic                  mul_done;
	logic                  mul_ack;
	logic [reg_addr_w-1:0] mul_wb_rd;
	logic [xlen-1:0]       mul_wb_data;

	logic                  wr_en;
	logic [reg_addr_w-1:0] wr_addr;
	logic [xlen-1:0]       wr_data;

	int_exec_unit i_int_exec_unit (
		.clk          (clk),
		.arst_n       (arst_n),
		.alu_issue    (alu_issue),
		.alu_op       (alu_op),
		.alu_a        (alu_a),
		.alu_b        (alu_b),
		.alu_rd       (alu_rd),
		.int_wb_valid (int_wb_valid),
		.int_wb_rd    (int_wb_rd),
		.int_wb_data  (int_wb_data)
	);

	mul_unit i_mul_unit (
		.clk         (clk),
		.arst_n      (arst_n),
		.mul_issue   (mul_issue),
		.mul_op      (mul_op),
		.mul_a       (mul_a),
		.mul_b       (mul_b),
		.mul_rd      (mul_rd),
		.mul_ack     (mul_ack),
		.mul_busy    (mul_busy),
		.mul_done    (mul_done),
		.mul_wb_rd   (mul_wb_rd),
		.mul_wb_data (mul_wb_data)
	);

	wb_arbiter i_wb_arbiter (
		.int_wb_valid (int_wb_valid),
		.int_wb_rd    (int_wb_rd),
		.int_wb_data  (int_wb_data),
		.mul_done     (mul_done),
		.mul_wb_rd    (mul_wb_rd),
		.mul_wb_data  (mul_wb_data),
		.mul_ack      (mul_ack),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data)
	);

	reg_file i_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file import exec_pkg::*, regfile_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  wr_en,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic [xlen-1:0]       wr_data,
	input  logic [reg_addr_w-1:0] rd_addr,
	output logic [xlen-1:0]       rd_data
);

	logic [xlen-1:0] regs [reg_count];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data; // x0 writes dropped
		end
	end

	assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

// ==== hdl/wb_arbiter.sv ====
`timescale 1ns/100ps

module wb_arbiter import exec_pkg::*, regfile_pkg::*; (
	input  logic                  int_wb_valid,
	input  logic [reg_addr_w-1:0] int_wb_rd,
	input  logic [xlen-1:0]       int_wb_data,
	input  logic                  mul_done,
	input  logic [reg_addr_w-1:0] mul_wb_rd,
	input  logic [xlen-1:0]       mul_wb_data,
	output logic                  mul_ack,
	output logic                  wr_en,
	output logic [reg_addr_w-1:0] wr_addr,
	output logic [xlen-1:0]       wr_data
);

	/*
	 * The integer unit has no storage, so it always wins. A finished
	 * multiply keeps mul_done and its result steady inside mul_unit
	 * until a free cycle turns up, and mul_ack then retires it.
	 */
	logic mul_grant;

	assign mul_grant = mul_done & ~int_wb_valid;

	assign mul_ack = mul_grant; // one pulse, the unit leaves done
	assign wr_en = int_wb_valid | mul_grant;

	always_comb begin
		if (int_wb_valid) begin
			wr_addr = int_wb_rd;
			wr_data = int_wb_data;
		end else begin
			wr_addr = mul_wb_rd; // don't care unless mul_grant
			wr_data = mul_wb_data;
		end
	end

endmodule

// ==== hdl/mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit import exec_pkg::*, regfile_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  mul_issue,
	input  logic [mul_op_w-1:0]   mul_op,
	input  logic [xlen-1:0]       mul_a,
	input  logic [xlen-1:0]       mul_b,
	input  logic [reg_addr_w-1:0] mul_rd,
	input  logic                  mul_ack,
	output logic                  mul_busy,
	output logic                  mul_done,
	output logic [reg_addr_w-1:0] mul_wb_rd,
	output logic [xlen-1:0]       mul_wb_data
);

	typedef enum logic [1:0] {st_idle, st_run, st_fix, st_done} mul_state_t;

	mul_state_t         state;
	logic [shamt_w-1:0] step_cnt; // 32 steps
	logic [xlen-1:0]    mcand;
	logic [2*xlen-1:0]  acc; // high half sums, low half holds the multiplier
	logic               neg_q; // product sign for mul_h
	logic [mul_op_w-1:0] op_q;

	// magnitudes for the signed case
	logic            is_signed;
	logic            a_neg;
	logic            b_neg;
	logic [xlen-1:0] a_mag;
	logic [xlen-1:0] b_mag;

	assign is_signed = mul_op == mul_h;
	assign a_neg = is_signed & mul_a[xlen-1];
	assign b_neg = is_signed & mul_b[xlen-1];
	assign a_mag = a_neg ? -mul_a : mul_a;
	assign b_mag = b_neg ? -mul_b : mul_b;

	logic [xlen:0]     step_sum;
	logic [2*xlen-1:0] prod;

	assign step_sum = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, mcand} : '0);
	assign prod = neg_q ? -acc : acc; // sign fix-up

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			step_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (mul_issue) begin
						state <= st_run;
						step_cnt <= '0;
					end
				end
				st_run: begin
					step_cnt <= step_cnt + 1'b1;
					if (&step_cnt) begin
						state <= st_fix; // last step done
					end
				end
				st_fix: begin
					state <= st_done;
				end
				default: begin
					if (mul_ack) begin
						state <= st_idle; // result written
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			st_idle: begin
				if (mul_issue) begin
					mcand <= a_mag;
					acc <= {{xlen{1'b0}}, b_mag};
					neg_q <= a_neg ^ b_neg;
					op_q <= mul_op;
					mul_wb_rd <= mul_rd;
				end
			end
			st_run: begin
				acc <= {step_sum, acc[xlen-1:1]}; // add then shift right
			end
			st_fix: begin
				mul_wb_data <= (op_q == mul_lo) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];
			end
			default: begin
			end
		endcase
	end

	assign mul_busy = state != st_idle;
	assign mul_done = state == st_done;

endmodule

// ==== hdl/int_exec_unit.sv ====
`timescale 1ns/100ps

module int_exec_unit import exec_pkg::*, regfile_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  alu_issue,
	input  logic [alu_op_w-1:0]   alu_op,
	input  logic [xlen-1:0]       alu_a,
	input  logic [xlen-1:0]       alu_b,
	input  logic [reg_addr_w-1:0] alu_rd,
	output logic                  int_wb_valid,
	output logic [reg_addr_w-1:0] int_wb_rd,
	output logic [xlen-1:0]       int_wb_data
);

	logic                  issue_q; // operands sit in the alu
	logic [alu_op_w-1:0]   op_q;
	logic [xlen-1:0]       a_q;
	logic [xlen-1:0]       b_q;
	logic [reg_addr_w-1:0] rd_q;
	logic [xlen-1:0]       alu_res;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			issue_q <= 1'b0;
			int_wb_valid <= 1'b0;
		end else begin
			issue_q <= alu_issue;
			int_wb_valid <= issue_q; // one cycle per issue
		end
	end

	// operand capture
	always_ff @(posedge clk) begin
		if (alu_issue) begin
			op_q <= alu_op;
			a_q <= alu_a;
			b_q <= alu_b;
			rd_q <= alu_rd;
		end
	end

	// write-back stage
	always_ff @(posedge clk) begin
		if (issue_q) begin
			int_wb_rd <= rd_q;
			int_wb_data <= alu_res;
		end
	end

	panda_risc_v_alu i_alu (
		.op_mode (op_q),
		.op1     (a_q),
		.op2     (b_q),
		.res     (alu_res)
	);

endmodule

// ==== hdl/panda_risc_v_alu.sv ====
`timescale 1ns/100ps

module panda_risc_v_alu import exec_pkg::*; (
	input  logic [alu_op_w-1:0] op_mode,
	input  logic [xlen-1:0]     op1,
	input  logic [xlen-1:0]     op2,
	output logic [xlen-1:0]     res
);

	// decoded operation flags
	logic is_sub;
	logic is_eq;
	logic is_neq;
	logic is_geq; // either geq flavour
	logic is_sgn; // signed ordered compare
	logic is_sll;
	logic is_sra;

	assign is_sub = op_mode == op_sub;
	assign is_eq = op_mode == op_equ;
	assign is_neq = op_mode == op_nequ;
	assign is_geq = (op_mode == op_sgn_geq) | (op_mode == op_usgn_geq);
	assign is_sgn = (op_mode == op_sgn_lt) | (op_mode == op_sgn_geq);
	assign is_sll = op_mode == op_sll;
	assign is_sra = op_mode == op_sra;

	function automatic logic [xlen-1:0] bit_rev(input logic [xlen-1:0] v);
		logic [xlen-1:0] r;
		for (int i = 0; i < xlen; i++) begin
			r[i] = v[xlen-1-i];
		end
		return r;
	endfunction

	// shared adder, subtracts for sub and the equality tests
	logic            adder_sub;
	logic [xlen-1:0] adder_b;
	logic [xlen-1:0] adder_out;

	assign adder_sub = is_sub | is_eq | is_neq;
	assign adder_b = op2 ^ {xlen{adder_sub}}; // invert for two's complement
	assign adder_out = op1 + adder_b + {{(xlen-1){1'b0}}, adder_sub};

	// equality from the difference
	logic eq_res;

	assign eq_res = (adder_out == '0) ^ is_neq;

	// ordered compare on 33 bits covers signed and unsigned
	logic [xlen:0] op1_ext;
	logic [xlen:0] op2_ext;
	logic          lt_raw;
	logic          lt_res;

	assign op1_ext = {is_sgn & op1[xlen-1], op1};
	assign op2_ext = {is_sgn & op2[xlen-1], op2};
	assign lt_raw = $signed(op1_ext) < $signed(op2_ext);
	assign lt_res = lt_raw ^ is_geq; // geq is the inverted lt

	/*
	 * One left shifter does all three shifts. Right shifts reverse the
	 * operand on the way in and the result on the way out, and sra then
	 * fills the vacated top bits with the sign.
	 */
	logic [shamt_w-1:0] shamt;
	logic [xlen-1:0]    shl_in;
	logic [xlen-1:0]    shl_out;
	logic [xlen-1:0]    shift_lr;
	logic [xlen-1:0]    sra_mask;
	logic [xlen-1:0]    shift_res;

	assign shamt = op2[shamt_w-1:0];
	assign shl_in = is_sll ? op1 : bit_rev(op1);
	assign shl_out = shl_in << shamt;
	assign shift_lr = is_sll ? shl_out : bit_rev(shl_out);
	assign sra_mask = {xlen{is_sra & op1[xlen-1]}} & ~({xlen{1'b1}} >> shamt);
	assign shift_res = shift_lr | sra_mask;

	// result select
	always_comb begin
		case (op_mode)
			op_add,
			op_sub: begin
				res = adder_out;
			end
			op_equ,
			op_nequ: begin
				res = {{(xlen-1){1'b0}}, eq_res};
			end
			op_sgn_lt,
			op_sgn_geq,
			op_usgn_lt,
			op_usgn_geq: begin
				res = {{(xlen-1){1'b0}}, lt_res};
			end
			op_xor: begin
				res = op1 ^ op2;
			end
			op_or: begin
				res = op1 | op2;
			end
			op_and: begin
				res = op1 & op2;
			end
			op_sll,
			op_srl,
			op_sra: begin
				res = shift_res;
			end
			default: begin
				res = '0; // codes 14 and 15 unused
			end
		endcase
	end

endmodule

// ==== hdl/regfile_pkg.sv ====
package regfile_pkg;

	localparam int reg_count = 32; // x0 .. x31
	localparam int reg_addr_w = 5; // log2 of reg_count

endpackage

// ==== hdl/exec_pkg.sv ====
package exec_pkg;

	localparam int xlen = 32; // data word width
	localparam int shamt_w = 5; // shift amount, log2 of xlen
	localparam int alu_op_w = 4; // op_mode width

	// alu operation codes
	localparam logic [alu_op_w-1:0] op_add = 4'd0;
	localparam logic [alu_op_w-1:0] op_sub = 4'd1;
	localparam logic [alu_op_w-1:0] op_equ = 4'd2; // 1 if op1 == op2
	localparam logic [alu_op_w-1:0] op_nequ = 4'd3; // 1 if op1 != op2
	localparam logic [alu_op_w-1:0] op_sgn_lt = 4'd4;
	localparam logic [alu_op_w-1:0] op_sgn_geq = 4'd5;
	localparam logic [alu_op_w-1:0] op_usgn_lt = 4'd6;
	localparam logic [alu_op_w-1:0] op_usgn_geq = 4'd7;
	localparam logic [alu_op_w-1:0] op_xor = 4'd8;
	localparam logic [alu_op_w-1:0] op_or = 4'd9;
	localparam logic [alu_op_w-1:0] op_and = 4'd10;
	localparam logic [alu_op_w-1:0] op_sll = 4'd11; // logical left
	localparam logic [alu_op_w-1:0] op_srl = 4'd12; // logical right
	localparam logic [alu_op_w-1:0] op_sra = 4'd13; // arithmetic right

	localparam int mul_op_w = 2; // multiplier op width

	// multiplier operations
	localparam logic [mul_op_w-1:0] mul_lo = 2'd0; // low word, sign does not matter
	localparam logic [mul_op_w-1:0] mul_hu = 2'd1; // high word, unsigned x unsigned
	localparam logic [mul_op_w-1:0] mul_h = 2'd2; // high word, signed x signed

endpackage
